// File: flist.f
+incdir+include
source/dphy_rx_pkg.sv
source/dphy_byte_align.sv
source/dphy_word_align.sv
source/dphy_32b_map.sv
source/dphy_credit_tx.sv
source/dphy_rx.sv
dv/dphy_rx_checker.sv
dv/dphy_rx_tb.sv

// File: dv/dphy_rx_tb.sv
`timescale 1ns/1ps
`include "dphy_rx_config.svh"

module dphy_rx_tb;
  import dphy_rx_pkg::*;

  localparam int LANES        = `DPHY_DATA_LANES;
  localparam int LEN_ALIGNED  = 16;
  localparam int LEN_OFFSET   = 16;
  localparam int LEN_SKEW     = 13;
  localparam int LEN_FIRST    = 12;
  localparam int LEN_SECOND   = 10;
  localparam int LEN_STARVE   = 24;
  localparam int DROPPED      = 2;
  localparam int LEN_OVERFLOW = (`DPHY_FIFO_DEPTH + `DPHY_OUT_CREDITS + DROPPED) * 4;

  function automatic int word_count(input int len);
    return (len + 3) / 4;
  endfunction

  localparam int TEST_WORDS = word_count(LEN_ALIGNED) + word_count(LEN_OFFSET)
                            + word_count(LEN_SKEW) + word_count(LEN_FIRST)
                            + word_count(LEN_SECOND) + word_count(LEN_STARVE)
                            + word_count(LEN_OVERFLOW);
  localparam int WATCHDOG_CYCLES = 200 * TEST_WORDS + 1000;

  logic        byte_clk;
  logic        rst_n_i;
  logic        enable_i;
  logic        pkt_done_i;
  lane_bytes_t byte_data_i;
  logic        credit_i;
  word_beat_t  out_beat_o;
  logic        out_valid_o;
  logic        overflow_o;

  integer      seed = 32'h2fba5c24;
  string       test_name = "reset";
  logic [7:0]  pkt [$];
  int          zbits [LANES];  // idle bits ahead of the sync byte per lane
  word_beat_t  exp_q [$];
  word_beat_t  expected_word;
  int          rcv_count = 0;
  int          owed = 0;        // words not yet paid back with a credit
  logic        withhold = 1'b0;

  dphy_rx dut
  (
    .byte_clk_i  ( byte_clk    ),
    .rst_n_i     ( rst_n_i     ),
    .enable_i    ( enable_i    ),
    .pkt_done_i  ( pkt_done_i  ),
    .byte_data_i ( byte_data_i ),
    .credit_i    ( credit_i    ),
    .out_beat_o  ( out_beat_o  ),
    .out_valid_o ( out_valid_o ),
    .overflow_o  ( overflow_o  )
  );

  initial
  begin
    byte_clk = 1'b0;
    forever #2 byte_clk = ~byte_clk;
  end

  task automatic report_failure(input string line);
    $display("%s", line);
    $display("Some tests failed");
    $fatal(1);
  endtask

  // bit t of a lane's serial stream, lsb first
  function automatic logic lane_bit(input int lane, input int t);
    logic [7:0] sync;
    int         k;
    sync = `DPHY_SYNC_BYTE;
    if (t < zbits[lane])
      return 1'b0;
    if (t < zbits[lane] + 8)
      return sync[t - zbits[lane]];
    k = ((t - zbits[lane] - 8) / 8) * LANES + lane;  // packet byte k rides lane k mod N
    if (k < pkt.size())
      return pkt[k][(t - zbits[lane] - 8) % 8];
    return 1'b0;
  endfunction

  function automatic logic [7:0] lane_byte(input int lane, input int c);
    logic [7:0] b;
    for (int j = 0; j < 8; j++)
      b[j] = lane_bit(lane, 8 * c + j);
    return b;
  endfunction

  // random payload and its expected words
  task automatic load_packet(input int len);
    word_beat_t w;
    int         words;
    pkt.delete();
    for (int i = 0; i < len; i++)
      pkt.push_back(8'($random(seed)));
    words = word_count(len);
    for (int m = 0; m < words; m++)
    begin
      w.data = '0;  // zero padding past the packet end
      for (int j = 0; j < 4; j++)
      begin
        if (4 * m + j < len)
          w.data[8 * j +: 8] = pkt[4 * m + j];
      end
      w.last = (m == words - 1);
      exp_q.push_back(w);
    end
  endtask

  task automatic send_packet();
    int          max_n;
    int          beats;
    int          done_cycle;
    lane_bytes_t lanes;
    max_n = 0;
    for (int l = 0; l < LANES; l++)
    begin
      if (zbits[l] / 8 + 1 > max_n)
        max_n = zbits[l] / 8 + 1;  // cycle in which this lane's sync completes
    end
    beats      = (pkt.size() + LANES - 1) / LANES;
    done_cycle = max_n + 2 + beats;  // first byte past the packet on the latest lane
    for (int c = 0; c <= done_cycle + 3; c++)
    begin
      @(posedge byte_clk);
      for (int l = 0; l < LANES; l++)
        lanes[l] = lane_byte(l, c);
      byte_data_i <= lanes;
      pkt_done_i  <= (c == done_cycle);
    end
  endtask

  task automatic wait_drained();
    @(negedge byte_clk);
    while (exp_q.size() != 0 || owed != 0)
      @(negedge byte_clk);
    repeat (8) @(negedge byte_clk);
  endtask

  task automatic reset_dut();
    @(posedge byte_clk);
    rst_n_i <= 1'b0;
    repeat (10) @(posedge byte_clk);
    rst_n_i <= 1'b1;
  endtask

  task automatic check_overflow(input logic exp);
    @(negedge byte_clk);
    assert (overflow_o == exp)
    else report_failure($sformatf("ERR %s expected %b actual %b", test_name, exp, overflow_o));
  endtask

  task automatic test_aligned_lanes();
    test_name = "aligned_lanes";
    for (int l = 0; l < LANES; l++)
      zbits[l] = 0;
    load_packet(LEN_ALIGNED);
    send_packet();
    wait_drained();
  endtask

  task automatic test_bit_offsets();
    test_name = "bit_offsets";
    for (int l = 0; l < LANES; l++)
      zbits[l] = 1 + $unsigned($random(seed)) % 7;
    load_packet(LEN_OFFSET);
    send_packet();
    wait_drained();
  endtask

  task automatic test_lane_skew();
    test_name = "lane_skew";
    zbits[0] = $unsigned($random(seed)) % 8;
    for (int l = 1; l < LANES; l++)
      zbits[l] = 8 * (1 + $unsigned($random(seed)) % 3) + $unsigned($random(seed)) % 8;
    load_packet(LEN_SKEW);
    send_packet();
    wait_drained();
  endtask

  task automatic test_back_to_back();
    test_name = "back_to_back";
    for (int l = 0; l < LANES; l++)
      zbits[l] = 8 * ($unsigned($random(seed)) % 4) + $unsigned($random(seed)) % 8;
    load_packet(LEN_FIRST);
    send_packet();
    for (int l = 0; l < LANES; l++)
      zbits[l] = 8 * ($unsigned($random(seed)) % 4) + $unsigned($random(seed)) % 8;
    load_packet(LEN_SECOND);
    send_packet();
    wait_drained();
  endtask

  task automatic test_credit_starvation();
    int base;
    test_name = "credit_starvation";
    for (int l = 0; l < LANES; l++)
      zbits[l] = 0;
    @(negedge byte_clk);
    base     = rcv_count;
    withhold = 1'b1;
    load_packet(LEN_STARVE);
    send_packet();
    repeat (20) @(negedge byte_clk);
    assert (rcv_count - base == `DPHY_OUT_CREDITS)
    else report_failure($sformatf("ERR %s expected %0d actual %0d", test_name,
                                  `DPHY_OUT_CREDITS, rcv_count - base));
    withhold = 1'b0;
    wait_drained();
    check_overflow(1'b0);
  endtask

  task automatic test_overflow();
    test_name = "overflow";
    for (int l = 0; l < LANES; l++)
      zbits[l] = $unsigned($random(seed)) % 8;
    withhold = 1'b1;
    load_packet(LEN_OVERFLOW);
    for (int i = 0; i < DROPPED; i++)
      void'(exp_q.pop_back());  // words pushed into a full fifo never come out
    send_packet();
    repeat (20) @(negedge byte_clk);
    check_overflow(1'b1);
    withhold = 1'b0;
    wait_drained();
    check_overflow(1'b1);
    reset_dut();
    check_overflow(1'b0);
  endtask

  // word monitor and reference compare
  always @(posedge byte_clk)
  begin
    if (rst_n_i && out_valid_o)
    begin
      assert (exp_q.size() != 0)
      else report_failure($sformatf("%s: output word %h arrived when none was expected",
                                    test_name, out_beat_o));
      expected_word = exp_q.pop_front();
      assert (out_beat_o == expected_word)
      else report_failure($sformatf("ERR %s expected %h actual %h", test_name,
                                    expected_word, out_beat_o));
      rcv_count++;
      owed++;
    end
  end

  always @(posedge byte_clk)
  begin
    assert (dut.handshake_checker.fire_count == 0)
    else report_failure("an output handshake assertion in the checker failed");
  end

  initial
  begin : credit_return
    int delay;
    forever
    begin
      @(posedge byte_clk);
      if (owed > 0 && !withhold)
      begin
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) @(posedge byte_clk);
        credit_i <= 1'b1;
        owed--;
        @(posedge byte_clk);
        credit_i <= 1'b0;
      end
    end
  end

  initial
  begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge byte_clk);
    report_failure($sformatf("timeout, the run did not finish within %0d cycles",
                             WATCHDOG_CYCLES));
  end

  initial
  begin
    rst_n_i     <= 1'b0;
    enable_i    <= 1'b0;
    pkt_done_i  <= 1'b0;
    byte_data_i <= '0;
    credit_i    <= 1'b0;
    reset_dut();
    enable_i <= 1'b1;
    test_aligned_lanes();
    test_bit_offsets();
    test_lane_skew();
    test_back_to_back();
    test_credit_starvation();
    test_overflow();
    repeat (10) @(posedge byte_clk);
    $display("All tests passed");
    $finish;
  end

endmodule

// File: dv/dphy_rx_checker.sv
`timescale 1ns/1ps
`include "dphy_rx_config.svh"

module dphy_rx_checker (
  input logic byte_clk_i,
  input logic rst_n_i,
  input logic credit_i,
  input logic out_valid_i,
  input logic overflow_i
);

  int credits;
  int fire_count = 0;  // read by the testbench

  always_ff @(posedge byte_clk_i)
  begin
    if (!rst_n_i)
      credits <= `DPHY_OUT_CREDITS;
    else
      credits <= credits + int'(credit_i) - int'(out_valid_i);
  end

  valid_needs_credit: assert property (
    @(posedge byte_clk_i) disable iff (!rst_n_i) out_valid_i |-> credits > 0)
  else
  begin
    $error("out_valid_o high with no credit left");
    fire_count++;
  end

  valid_low_after_reset: assert property (
    @(posedge byte_clk_i) !rst_n_i |=> !out_valid_i)
  else
  begin
    $error("out_valid_o high right after reset");
    fire_count++;
  end

  overflow_sticky: assert property (
    @(posedge byte_clk_i) disable iff (!rst_n_i)
    $past(rst_n_i) && $past(overflow_i) |-> overflow_i)
  else
  begin
    $error("overflow_o fell without reset");
    fire_count++;
  end

endmodule

bind dphy_rx dphy_rx_checker handshake_checker
(
  .byte_clk_i  ( byte_clk_i  ),
  .rst_n_i     ( rst_n_i     ),
  .credit_i    ( credit_i    ),
  .out_valid_i ( out_valid_o ),
  .overflow_i  ( overflow_o  )
);

// File: source/dphy_rx.sv
`timescale 1ns/1ps
`include "dphy_rx_config.svh"

module dphy_rx (
  input  logic                     byte_clk_i,
  input  logic                     rst_n_i,
  input  logic                     enable_i,
  input  logic                     pkt_done_i,
  input  dphy_rx_pkg::lane_bytes_t byte_data_i,
  input  logic                     credit_i,
  output dphy_rx_pkg::word_beat_t  out_beat_o,
  output logic                     out_valid_o,
  output logic                     overflow_o
);
  import dphy_rx_pkg::*;

  lane_bytes_t                 aligned_bytes;
  logic [`DPHY_DATA_LANES-1:0] aligned_valid;
  logic                        sync_reset;
  lane_beat_t                  lane_beat;
  word_beat_t                  word;
  logic                        word_valid;

  generate
    for (genvar i = 0; i < `DPHY_DATA_LANES; i++)
    begin : byte_align
      dphy_byte_align byte_aligner
      (
        .byte_clk_i       ( byte_clk_i       ),
        .rst_n_i          ( rst_n_i          ),
        .enable_i         ( enable_i         ),
        .unaligned_byte_i ( byte_data_i[i]   ),
        .sync_reset_i     ( sync_reset       ),
        .aligned_byte_o   ( aligned_bytes[i] ),
        .valid_o          ( aligned_valid[i] )
      );
    end
  endgenerate

  dphy_word_align word_aligner
  (
    .byte_clk_i   ( byte_clk_i    ),
    .rst_n_i      ( rst_n_i       ),
    .enable_i     ( enable_i      ),
    .pkt_done_i   ( pkt_done_i    ),
    .byte_data_i  ( aligned_bytes ),
    .valid_i      ( aligned_valid ),
    .sync_reset_o ( sync_reset    ),
    .beat_o       ( lane_beat     )
  );

  dphy_32b_map mapper
  (
    .byte_clk_i ( byte_clk_i ),
    .rst_n_i    ( rst_n_i    ),
    .beat_i     ( lane_beat  ),
    .word_o     ( word       ),
    .valid_o    ( word_valid )
  );

  dphy_credit_tx credit_tx
  (
    .byte_clk_i  ( byte_clk_i  ),
    .rst_n_i     ( rst_n_i     ),
    .word_i      ( word        ),
    .valid_i     ( word_valid  ),
    .credit_i    ( credit_i    ),
    .out_beat_o  ( out_beat_o  ),
    .out_valid_o ( out_valid_o ),
    .overflow_o  ( overflow_o  )
  );

endmodule

// File: source/dphy_credit_tx.sv
`timescale 1ns/1ps
`include "dphy_rx_config.svh"

module dphy_credit_tx (
  input  logic                    byte_clk_i,
  input  logic                    rst_n_i,
  input  dphy_rx_pkg::word_beat_t word_i,
  input  logic                    valid_i,
  input  logic                    credit_i,
  output dphy_rx_pkg::word_beat_t out_beat_o,
  output logic                    out_valid_o,
  output logic                    overflow_o
);
  import dphy_rx_pkg::*;

  localparam int DEPTH   = `DPHY_FIFO_DEPTH;
  localparam int CREDITS = `DPHY_OUT_CREDITS;
  localparam int PW      = $clog2(DEPTH);
  localparam int CW      = $clog2(DEPTH + 1);
  localparam int KW      = $clog2(CREDITS + 1);

  word_beat_t    mem [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic [KW-1:0] credits;
  logic          full;
  logic          push;
  logic          pop;

  assign full        = (count == CW'(DEPTH));
  assign push        = valid_i && !full;
  assign out_valid_o = (count != '0) && (credits != '0);
  assign pop         = out_valid_o;  // each word sent spends a credit
  assign out_beat_o  = mem[rd_ptr];

  always_ff @(posedge byte_clk_i)
  begin
    if (push)
      mem[wr_ptr] <= word_i;
  end

  always_ff @(posedge byte_clk_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count <= count + CW'(push) - CW'(pop);
    end
  end

  always_ff @(posedge byte_clk_i)
  begin
    if (!rst_n_i)
      credits <= KW'(CREDITS);
    else
      credits <= credits + KW'(credit_i) - KW'(pop);
  end

  always_ff @(posedge byte_clk_i)
  begin
    if (!rst_n_i)
      overflow_o <= 1'b0;
    else if (valid_i && full)
      overflow_o <= 1'b1;  // word dropped, sticky
  end

endmodule

// File: source/dphy_32b_map.sv
`timescale 1ns/1ps
`include "dphy_rx_config.svh"

module dphy_32b_map (
  input  logic                    byte_clk_i,
  input  logic                    rst_n_i,
  input  dphy_rx_pkg::lane_beat_t beat_i,
  output dphy_rx_pkg::word_beat_t word_o,
  output logic                    valid_o
);

  localparam int LANES = `DPHY_DATA_LANES;
  localparam int BEATS = 4 / LANES;

  logic [31:0] acc;
  logic [31:0] acc_next;
  logic [31:0] hold;
  logic [1:0]  cnt;
  logic        word_done;
  logic        hold_valid;
  logic        send;
  logic        send_last;
  logic [31:0] send_data;

  assign word_done = (cnt == 2'(BEATS - 1));

  // beat b, lane j lands in byte b*LANES+j of the word
  always_comb
  begin
    acc_next = acc;
    for (int j = 0; j < LANES; j++)
      acc_next[8 * (int'(cnt) * LANES + j) +: 8] = beat_i.bytes[j];
  end

  always_comb
  begin
    send      = 1'b0;
    send_last = 1'b0;
    send_data = hold;
    if (beat_i.flush)
    begin
      send      = hold_valid || (cnt != 2'd0);
      send_last = 1'b1;
      if (!hold_valid)
        send_data = acc;  // zero padded partial word
    end
    else if (beat_i.valid && hold_valid)
    begin
      send = 1'b1;  // held word leaves once the next word starts
    end
  end

  always_ff @(posedge byte_clk_i)
  begin
    if (!rst_n_i)
    begin
      acc        <= '0;
      cnt        <= 2'd0;
      hold_valid <= 1'b0;
    end
    else if (beat_i.flush)
    begin
      acc        <= '0;
      cnt        <= 2'd0;
      hold_valid <= 1'b0;
    end
    else if (beat_i.valid)
    begin
      if (word_done)
      begin
        acc        <= '0;
        cnt        <= 2'd0;
        hold       <= acc_next;
        hold_valid <= 1'b1;
      end
      else
      begin
        acc        <= acc_next;
        cnt        <= cnt + 2'd1;
        hold_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge byte_clk_i)
  begin
    word_o <= '{data: send_data, last: send_last};
  end

  always_ff @(posedge byte_clk_i)
  begin
    if (!rst_n_i)
      valid_o <= 1'b0;
    else
      valid_o <= send;
  end

endmodule

// File: source/dphy_word_align.sv
`timescale 1ns/1ps
`include "dphy_rx_config.svh"

module dphy_word_align (
  input  logic                        byte_clk_i,
  input  logic                        rst_n_i,
  input  logic                        enable_i,
  input  logic                        pkt_done_i,
  input  dphy_rx_pkg::lane_bytes_t    byte_data_i,
  input  logic [`DPHY_DATA_LANES-1:0] valid_i,
  output logic                        sync_reset_o,
  output dphy_rx_pkg::lane_beat_t     beat_o
);
  import dphy_rx_pkg::*;

  localparam int LANES = `DPHY_DATA_LANES;
  localparam int DEPTH = 4;

  logic [7:0]       mem [LANES][DEPTH];
  logic [1:0]       wr_ptr [LANES];
  logic [1:0]       rd_ptr [LANES];
  logic [2:0]       count [LANES];
  logic [LANES-1:0] not_empty;
  logic [LANES-1:0] push;
  logic             pop;
  logic             drain;
  logic             flush_now;
  lane_bytes_t      head;
  lane_bytes_t      beat_bytes;
  logic             beat_valid;
  logic             beat_flush;

  // bytes seen with or after pkt_done_i are not part of the packet
  always_comb
  begin
    for (int i = 0; i < LANES; i++)
    begin
      not_empty[i] = (count[i] != 3'd0);
      push[i]      = enable_i && valid_i[i] && !pkt_done_i && !drain && !sync_reset_o;
      head[i]      = mem[i][rd_ptr[i]];
    end
  end

  assign pop       = &not_empty;  // every lane holds its byte of the beat
  assign flush_now = drain && !pop;

  always_ff @(posedge byte_clk_i)
  begin
    for (int i = 0; i < LANES; i++)
    begin
      if (push[i])
        mem[i][wr_ptr[i]] <= byte_data_i[i];
    end
  end

  always_ff @(posedge byte_clk_i)
  begin
    if (!rst_n_i || flush_now)
    begin
      for (int i = 0; i < LANES; i++)
      begin
        wr_ptr[i] <= 2'd0;
        rd_ptr[i] <= 2'd0;
        count[i]  <= 3'd0;
      end
    end
    else
    begin
      for (int i = 0; i < LANES; i++)
      begin
        if (push[i])
          wr_ptr[i] <= wr_ptr[i] + 2'd1;
        if (pop)
          rd_ptr[i] <= rd_ptr[i] + 2'd1;
        count[i] <= count[i] + 3'(push[i]) - 3'(pop);
      end
    end
  end

  always_ff @(posedge byte_clk_i)
  begin
    beat_bytes <= head;
  end

  always_ff @(posedge byte_clk_i)
  begin
    if (!rst_n_i)
    begin
      beat_valid   <= 1'b0;
      beat_flush   <= 1'b0;
      sync_reset_o <= 1'b0;
      drain        <= 1'b0;
    end
    else
    begin
      beat_valid   <= pop;
      beat_flush   <= flush_now;
      sync_reset_o <= flush_now;  // aligners search for the next sync
      if (flush_now)
        drain <= 1'b0;
      else if (pkt_done_i)
        drain <= 1'b1;
    end
  end

  assign beat_o = '{bytes: beat_bytes, valid: beat_valid, flush: beat_flush};

endmodule

// File: source/dphy_byte_align.sv
`timescale 1ns/1ps
`include "dphy_rx_config.svh"

module dphy_byte_align (
  input  logic       byte_clk_i,
  input  logic       rst_n_i,
  input  logic       enable_i,
  input  logic [7:0] unaligned_byte_i,
  input  logic       sync_reset_i,
  output logic [7:0] aligned_byte_o,
  output logic       valid_o
);

  logic [7:0]  prev_byte;
  logic [15:0] window;
  logic        locked;
  logic [2:0]  offset;
  logic        hit;
  logic [2:0]  hit_offset;

  assign window = {unaligned_byte_i, prev_byte};  // older bits in the low half

  // lowest matching offset wins
  always_comb
  begin
    hit        = 1'b0;
    hit_offset = 3'd0;
    for (int i = 7; i >= 0; i--)
    begin
      if (window[i +: 8] == `DPHY_SYNC_BYTE)
      begin
        hit        = 1'b1;
        hit_offset = 3'(i);
      end
    end
  end

  always_ff @(posedge byte_clk_i)
  begin
    prev_byte <= unaligned_byte_i;
  end

  always_ff @(posedge byte_clk_i)
  begin
    if (!rst_n_i || sync_reset_i)
    begin
      locked <= 1'b0;
      offset <= 3'd0;
    end
    else if (enable_i && !locked && hit)
    begin
      locked <= 1'b1;
      offset <= hit_offset;
    end
  end

  always_ff @(posedge byte_clk_i)
  begin
    aligned_byte_o <= window[offset +: 8];
  end

  always_ff @(posedge byte_clk_i)
  begin
    if (!rst_n_i || sync_reset_i)
    begin
      valid_o <= 1'b0;
    end
    else
    begin
      valid_o <= locked && enable_i;  // first byte after the sync byte
    end
  end

endmodule

// File: source/dphy_rx_pkg.sv
`include "dphy_rx_config.svh"

package dphy_rx_pkg;

  // one byte per data lane, lane 0 in the low byte
  typedef logic [`DPHY_DATA_LANES-1:0][7:0] lane_bytes_t;

  // deskewed beat across all lanes
  typedef struct packed {
    lane_bytes_t bytes;
    logic        valid;
    logic        flush;  // packet end, no data
  } lane_beat_t;

  typedef struct packed {
    logic [31:0] data;
    logic        last;
  } word_beat_t;

endpackage

// File: include/dphy_rx_config.svh
`ifndef DPHY_RX_CONFIG_SVH
`define DPHY_RX_CONFIG_SVH

// data lanes in use, 1, 2 or 4
`define DPHY_DATA_LANES 2

// hs sync byte, received lsb first
`define DPHY_SYNC_BYTE 8'hB8

// credits held by the output stage after reset
`define DPHY_OUT_CREDITS 4

// output fifo depth in words
`define DPHY_FIFO_DEPTH 8

`endif
